//--- common/uart_reg_pkg.sv
// uart register controller shared constants, register map and bus structs
package uart_reg_pkg;

    // ----------------------------------------------------------------------
    // frame codes
    // ----------------------------------------------------------------------
    localparam logic [31:0] head_code  = 32'he7e7_e7e7;  // precedes every host frame
    localparam logic [7:0]  reply_code = 8'h55;          // first byte of each reply

    // ----------------------------------------------------------------------
    // register map, 7-bit addresses
    // ----------------------------------------------------------------------
    localparam logic [6:0] addr_version   = 7'h00;  // read only
    localparam logic [6:0] addr_test      = 7'h02;  // scratch byte
    localparam logic [6:0] addr_hotreset  = 7'h04;  // hot reset enable in bit 0
    localparam logic [6:0] addr_switch    = 7'h0e;  // open/clear enables, switch number
    localparam logic [6:0] addr_status_lo = 7'h31;  // status word [7:0]
    localparam logic [6:0] addr_status_hi = 7'h32;  // status word [15:8]

    // ----------------------------------------------------------------------
    // structs
    // ----------------------------------------------------------------------

    // one register access decoded from the rx stream
    typedef struct packed {
        logic       valid;  // single cycle strobe
        logic       write;  // 0 for a read
        logic [6:0] addr;
        logic [7:0] wdata;
    } reg_access_t;

    // queued read answer, sent as 55, addr, data
    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] data;
    } reg_reply_t;

    // control outputs toward the configuration logic
    typedef struct packed {
        logic       hotreset_en;
        logic       open_sw_en;
        logic       clear_sw_en;
        logic [1:0] open_sw_num;
    } ctrl_out_t;

endpackage

//--- source/sync_fifo.sv
// single clock FIFO with type parameter payload and full, almost full, empty flags
`timescale 1ns/1ns
module sync_fifo #(
    parameter type payload_t   = logic [7:0],
    parameter int  depth       = 32,
    parameter int  afull_level = 16
) (
    input  logic     sys_clk,
    input  logic     sys_rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head_data,
    output logic     full,
    output logic     afull,
    output logic     empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t           mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic               do_push;
    logic               do_pop;

    assign do_push = push && !full;   // overflow is dropped
    assign do_pop  = pop && !empty;

    assign full      = (count == cnt_w'(depth));
    assign afull     = (count >= cnt_w'(afull_level));
    assign empty     = (count == '0);
    assign head_data = mem[rd_ptr];   // head visible the cycle after a push

    always_ff @(posedge sys_clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

endmodule

//--- cmd_path/frame_parser.sv
// rx byte stream parser, finds write and read frames and issues register accesses
`timescale 1ns/1ns
module frame_parser (
    input  logic                      sys_clk,
    input  logic                      sys_rst_n,
    input  logic [7:0]                rx_data,
    input  logic                      rx_valid,
    output uart_reg_pkg::reg_access_t access
);

    logic [39:0] rx_hist;   // last five rx bytes, newest in [7:0]
    logic        wr_hit;
    logic        rd_hit;

    // ----------------------------------------------------------------------
    // frame detection on the current byte
    // ----------------------------------------------------------------------

    // head, address with bit 7 clear, then the current byte is the data
    assign wr_hit = rx_valid
                 && (rx_hist[39:8] == uart_reg_pkg::head_code)
                 && !rx_hist[7];

    // head, then the current byte is an address with bit 7 set
    assign rd_hit = rx_valid
                 && (rx_hist[31:0] == uart_reg_pkg::head_code)
                 && rx_data[7];

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            rx_hist <= '0;
        else if (rx_valid)
            rx_hist <= {rx_hist[31:0], rx_data};   // shift in newest byte
    end

    // ----------------------------------------------------------------------
    // access register, one cycle after the closing byte
    // ----------------------------------------------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            access <= '0;
        end
        else
        begin
            access.valid <= wr_hit || rd_hit;   // the two hits never overlap
            access.write <= wr_hit;
            if (wr_hit)
            begin
                access.addr  <= rx_hist[6:0];
                access.wdata <= rx_data;
            end
            else if (rd_hit)
            begin
                access.addr  <= rx_data[6:0];
                access.wdata <= '0;
            end
        end
    end

endmodule

//--- cmd_path/reg_bank.sv
// register bank, applies writes, answers reads and pushes replies
`timescale 1ns/1ns
module reg_bank #(
    parameter logic [7:0] fpga_version = 8'h12
) (
    input  logic                      sys_clk,
    input  logic                      sys_rst_n,
    input  uart_reg_pkg::reg_access_t access,
    input  logic [15:0]               status_word,
    output uart_reg_pkg::ctrl_out_t   ctrl,
    output uart_reg_pkg::reg_reply_t  reply,
    output logic                      reply_push,
    input  logic                      reply_full
);

    logic [7:0] test_reg;
    logic       rd_known;       // read address is in the map
    logic [7:0] rd_data;
    logic       reply_pending;  // reply formed, waiting to enter the FIFO
    logic       rd_req;

    assign rd_req = access.valid && !access.write;

    // ----------------------------------------------------------------------
    // write side
    // ----------------------------------------------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            test_reg         <= 8'h00;
            ctrl.hotreset_en <= 1'b0;
            ctrl.open_sw_en  <= 1'b0;
            ctrl.clear_sw_en <= 1'b0;
            ctrl.open_sw_num <= 2'd1;   // switch 1 selected out of reset
        end
        else if (access.valid && access.write)
        begin
            case (access.addr)
                uart_reg_pkg::addr_test:     test_reg         <= access.wdata;
                uart_reg_pkg::addr_hotreset: ctrl.hotreset_en <= access.wdata[0];
                uart_reg_pkg::addr_switch:
                begin
                    ctrl.open_sw_en  <= access.wdata[6];
                    ctrl.clear_sw_en <= access.wdata[4];
                    ctrl.open_sw_num <= access.wdata[1:0];
                end
                default: ;                  // other addresses are read only or unmapped
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // read side
    // ----------------------------------------------------------------------
    always_comb
    begin
        rd_known = 1'b1;
        rd_data  = 8'h00;
        case (access.addr)
            uart_reg_pkg::addr_version:   rd_data = fpga_version;
            uart_reg_pkg::addr_test:      rd_data = test_reg;
            uart_reg_pkg::addr_hotreset:  rd_data = {7'b0, ctrl.hotreset_en};
            uart_reg_pkg::addr_switch:    rd_data = {1'b0, ctrl.open_sw_en, 1'b0,
                                                     ctrl.clear_sw_en, 2'b0,
                                                     ctrl.open_sw_num};
            uart_reg_pkg::addr_status_lo: rd_data = status_word[7:0];
            uart_reg_pkg::addr_status_hi: rd_data = status_word[15:8];
            default:                      rd_known = 1'b0;   // no reply
        endcase
    end

    always_ff @(posedge sys_clk)
    begin
        if (rd_req)
        begin
            reply.addr <= {1'b1, access.addr};   // echo the read address byte
            reply.data <= rd_data;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            reply_pending <= 1'b0;
        else
            reply_pending <= rd_req && rd_known;
    end

    assign reply_push = reply_pending && !reply_full;   // dropped when the FIFO is full

endmodule

//--- source/tx_arbiter.sv
// tx arbiter, merges flash bytes and framed replies into one valid/ready byte stream
`timescale 1ns/1ns
module tx_arbiter (
    input  logic                     sys_clk,
    input  logic                     sys_rst_n,
    input  uart_reg_pkg::reg_reply_t reply_head,
    input  logic                     reply_empty,
    output logic                     reply_pop,
    input  logic [7:0]               flash_head,
    input  logic                     flash_empty,
    output logic                     flash_pop,
    output logic [7:0]               tx_data,
    output logic                     tx_valid,
    input  logic                     tx_ready
);

    typedef enum logic [2:0] {
        st_idle,
        st_flash,
        st_reply_1,     // reply code
        st_reply_2,     // address
        st_reply_3      // data
    } tx_state_t;

    tx_state_t state;
    tx_state_t state_nxt;
    logic      xfer;

    assign tx_valid = (state != st_idle);
    assign xfer     = tx_valid && tx_ready;

    // pop when the last byte of the item leaves
    assign flash_pop = (state == st_flash) && xfer;
    assign reply_pop = (state == st_reply_3) && xfer;

    // ----------------------------------------------------------------------
    // byte select, held stable because the FIFO heads only move on pop
    // ----------------------------------------------------------------------
    always_comb
    begin
        case (state)
            st_flash:   tx_data = flash_head;
            st_reply_1: tx_data = uart_reg_pkg::reply_code;
            st_reply_2: tx_data = reply_head.addr;
            st_reply_3: tx_data = reply_head.data;
            default:    tx_data = 8'h00;
        endcase
    end

    // ----------------------------------------------------------------------
    // FSM
    // ----------------------------------------------------------------------
    always_comb
    begin
        state_nxt = state;
        case (state)
            st_idle:
            begin
                if (!flash_empty)
                    state_nxt = st_flash;       // flash wins at a reply boundary
                else if (!reply_empty)
                    state_nxt = st_reply_1;
            end
            st_flash:   if (xfer) state_nxt = st_idle;
            st_reply_1: if (xfer) state_nxt = st_reply_2;
            st_reply_2: if (xfer) state_nxt = st_reply_3;
            st_reply_3: if (xfer) state_nxt = st_idle;
            default:    state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            state <= st_idle;
        else
            state <= state_nxt;
    end

endmodule

//--- source/uart_reg_ctrl.sv
// uart register controller top, parser, register bank, reply and flash FIFOs, tx arbiter
`timescale 1ns/1ns
module uart_reg_ctrl #(
    parameter logic [7:0] fpga_version = 8'h12,
    parameter int         reply_depth  = 32,
    parameter int         flash_depth  = 512,
    parameter int         afull_level  = 256
) (
    input  logic                    sys_clk,
    input  logic                    sys_rst_n,
    input  logic [7:0]              rx_data,
    input  logic                    rx_valid,
    output logic [7:0]              tx_data,
    output logic                    tx_valid,
    input  logic                    tx_ready,
    input  logic [15:0]             status_word,
    input  logic [7:0]              flash_rd_data,
    input  logic                    flash_rd_valid,
    output logic                    flash_rd_afull,
    output uart_reg_pkg::ctrl_out_t ctrl
);

    uart_reg_pkg::reg_access_t access;
    uart_reg_pkg::reg_reply_t  reply;
    uart_reg_pkg::reg_reply_t  reply_head;
    logic                      reply_push;
    logic                      reply_pop;
    logic                      reply_full;
    logic                      reply_empty;
    logic [7:0]                flash_head;
    logic                      flash_push;
    logic                      flash_pop;
    logic                      flash_full;
    logic                      flash_empty;

    assign flash_push = flash_rd_valid && !flash_full;   // bytes past full are lost

    // ----------------------------------------------------------------------
    // command path
    // ----------------------------------------------------------------------
    frame_parser u_frame_parser (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .access    (access)
    );

    reg_bank #(
        .fpga_version (fpga_version)
    ) u_reg_bank (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .access      (access),
        .status_word (status_word),
        .ctrl        (ctrl),
        .reply       (reply),
        .reply_push  (reply_push),
        .reply_full  (reply_full)
    );

    // ----------------------------------------------------------------------
    // queues and tx
    // ----------------------------------------------------------------------
    sync_fifo #(
        .payload_t   (uart_reg_pkg::reg_reply_t),
        .depth       (reply_depth),
        .afull_level (reply_depth)
    ) u_reply_fifo (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .push      (reply_push),
        .push_data (reply),
        .pop       (reply_pop),
        .head_data (reply_head),
        .full      (reply_full),
        .afull     (),
        .empty     (reply_empty)
    );

    sync_fifo #(
        .payload_t   (logic [7:0]),
        .depth       (flash_depth),
        .afull_level (afull_level)
    ) u_flash_fifo (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .push      (flash_push),
        .push_data (flash_rd_data),
        .pop       (flash_pop),
        .head_data (flash_head),
        .full      (flash_full),
        .afull     (flash_rd_afull),
        .empty     (flash_empty)
    );

    tx_arbiter u_tx_arbiter (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .reply_head  (reply_head),
        .reply_empty (reply_empty),
        .reply_pop   (reply_pop),
        .flash_head  (flash_head),
        .flash_empty (flash_empty),
        .flash_pop   (flash_pop),
        .tx_data     (tx_data),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready)
    );

endmodule

//--- tests/tb_clock_gen.sv
// testbench clock and reset source, free running clock with a timed reset release
`timescale 1ns/1ns
module tb_clock_gen #(
    parameter int period       = 20,
    parameter int reset_cycles = 4
) (
    output logic sys_clk,
    output logic sys_rst_n
);

    initial
    begin
        sys_clk   = 1'b0;
        sys_rst_n = 1'b0;
        repeat (reset_cycles) @(posedge sys_clk);
        sys_rst_n <= 1'b1;   // released on the 4th rising edge
    end

    always #(period / 2) sys_clk = ~sys_clk;

endmodule

//--- tests/uart_reg_ctrl_properties.sv
// bound assertions on the tx valid/ready stream and the FIFO push strobes
`timescale 1ns/1ns
module uart_reg_ctrl_properties #(
    parameter int reply_depth = 32,
    parameter int flash_depth = 512
) (
    input logic       sys_clk,
    input logic       sys_rst_n,
    input logic [7:0] tx_data,
    input logic       tx_valid,
    input logic       tx_ready,
    input logic       reply_push,
    input logic       reply_pop,
    input logic       flash_push,
    input logic       flash_pop
);

    int reply_fill;         // items held, counted from the strobes
    int flash_fill;
    int assert_fails = 0;

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            reply_fill <= 0;
            flash_fill <= 0;
        end
        else
        begin
            reply_fill <= reply_fill + int'(reply_push) - int'(reply_pop);
            flash_fill <= flash_fill + int'(flash_push) - int'(flash_pop);
        end
    end

    // an offered byte stays put until it is taken
    tx_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
        else
        begin
            $error("tx_valid or tx_data changed before the transfer");
            assert_fails++;
        end

    reply_push_room: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        reply_push |-> reply_fill < reply_depth)
        else
        begin
            $error("reply FIFO pushed while full");
            assert_fails++;
        end

    flash_push_room: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        flash_push |-> flash_fill < flash_depth)
        else
        begin
            $error("flash FIFO pushed while full");
            assert_fails++;
        end

endmodule

bind uart_reg_ctrl uart_reg_ctrl_properties #(
    .reply_depth (reply_depth),
    .flash_depth (flash_depth)
) u_uart_reg_ctrl_properties (
    .sys_clk    (sys_clk),
    .sys_rst_n  (sys_rst_n),
    .tx_data    (tx_data),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .reply_push (reply_push),
    .reply_pop  (reply_pop),
    .flash_push (flash_push),
    .flash_pop  (flash_pop)
);

//--- tests/uart_reg_ctrl_tb.sv
// testbench for the uart register controller, table driven against a byte stream model
`timescale 1ns/1ns
module uart_reg_ctrl_tb;

    localparam logic [7:0]  tb_version = 8'h5a;
    localparam logic [15:0] tb_status  = 16'h9ac3;
    localparam int          tb_afull   = 8;      // low enough for the bursts to reach it
    localparam logic [1:0]  k_write    = 2'd0;
    localparam logic [1:0]  k_read     = 2'd1;
    localparam logic [1:0]  k_junk     = 2'd2;   // broken headers
    localparam logic [1:0]  k_flash    = 2'd3;

    typedef struct packed {
        logic [1:0] kind;
        logic [7:0] addr;   // burst length for flash entries
        logic [7:0] data;   // first byte for flash entries
        logic [7:0] exp;    // reply data for reads
    } entry_t;

    logic                    sys_clk;
    logic                    sys_rst_n;
    logic [7:0]              rx_data;
    logic                    rx_valid;
    logic [7:0]              tx_data;
    logic                    tx_valid;
    logic                    tx_ready;
    logic [15:0]             status_word;
    logic [7:0]              flash_rd_data;
    logic                    flash_rd_valid;
    logic                    flash_rd_afull;
    uart_reg_pkg::ctrl_out_t ctrl;

    entry_t                  stim[$];
    logic [7:0]              exp_flash[$];
    logic [15:0]             exp_reply[$];   // {addr byte, data}
    uart_reg_pkg::ctrl_out_t model_ctrl;
    int                      value_errors;
    int                      other_errors;
    int                      assert_errors;
    int                      reply_phase;    // 0 at a reply boundary
    int                      flash_level;    // bytes held in the flash FIFO
    logic [31:0]             lcg_state;

    tb_clock_gen #(.period(20), .reset_cycles(4)) u_clock_gen (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n)
    );

    uart_reg_ctrl #(.fpga_version(tb_version), .afull_level(tb_afull)) i_uart_reg_ctrl (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .tx_data        (tx_data),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready),
        .status_word    (status_word),
        .flash_rd_data  (flash_rd_data),
        .flash_rd_valid (flash_rd_valid),
        .flash_rd_afull (flash_rd_afull),
        .ctrl           (ctrl)
    );

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic is_mapped(input logic [6:0] a);
        return a inside {7'h00, 7'h02, 7'h04, 7'h0e, 7'h31, 7'h32};
    endfunction

    function automatic void add_entry(input logic [1:0] k, input logic [7:0] a,
                                      input logic [7:0] d, input logic [7:0] x);
        stim.push_back({k, a, d, x});
    endfunction

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
        begin
            $display("FAILED at %0t ns: %s expected %02h got %02h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge sys_clk);
        rx_data  <= b;
        rx_valid <= 1'b1;
    endtask

    task automatic send_head();
        repeat (4) send_byte(8'he7);
    endtask

    task automatic idle_for(input int n);
        @(posedge sys_clk);
        rx_valid       <= 1'b0;
        flash_rd_valid <= 1'b0;
        repeat (n - 1) @(posedge sys_clk);
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic apply_entry(input entry_t e);
        case (e.kind)
            k_write:
            begin
                send_head();
                send_byte({1'b0, e.addr[6:0]});
                send_byte(e.data);
                if (e.addr[6:0] == uart_reg_pkg::addr_hotreset)
                    model_ctrl.hotreset_en = e.data[0];
                if (e.addr[6:0] == uart_reg_pkg::addr_switch)
                    model_ctrl = {model_ctrl.hotreset_en, e.data[6], e.data[4], e.data[1:0]};
            end
            k_read:
            begin
                if (is_mapped(e.addr[6:0]))
                    exp_reply.push_back({1'b1, e.addr[6:0], e.exp});
                send_head();
                send_byte({1'b1, e.addr[6:0]});
            end
            k_junk:
            begin
                // broken write, then broken read of the same address
                send_byte(8'he7);
                send_byte(8'he7);
                send_byte(e.data);
                send_byte(8'he7);
                send_byte({1'b0, e.addr[6:0]});
                send_byte(8'h77);
                send_byte(8'he7);
                send_byte(e.data);
                send_byte(8'he7);
                send_byte(8'he7);
                send_byte({1'b1, e.addr[6:0]});
            end
            default:
            begin
                for (int i = 0; i < e.addr; i++)
                begin
                    @(posedge sys_clk);
                    flash_rd_data  <= e.data + 8'(i);
                    flash_rd_valid <= 1'b1;
                    exp_flash.push_back(e.data + 8'(i));
                end
            end
        endcase
        idle_for(3);   // ctrl settles 2 cycles after the last byte
        if (ctrl !== model_ctrl)
        begin
            $display("FAILED at %0t ns: ctrl expected %02h got %02h", $time, model_ctrl, ctrl);
            value_errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // tx monitor, splits the stream into flash bytes and replies
    // ----------------------------------------------------------------------
    task automatic take_tx_byte(input logic [7:0] b);
        logic [15:0] item;
        if (reply_phase == 0)
        begin
            if (b == uart_reg_pkg::reply_code && exp_reply.size() > 0)
                reply_phase = 1;     // flash bytes are never 55
            else if (exp_flash.size() > 0)
            begin
                check_byte("tx_data (flash byte)", exp_flash.pop_front(), b);
                flash_level--;       // byte left the flash FIFO
            end
            else
            begin
                $display("ERROR at %0t ns: tx byte %02h sent with nothing outstanding",
                         $time, b);
                other_errors++;
            end
        end
        else if (reply_phase == 1)
        begin
            item = exp_reply[0];
            check_byte("tx_data (reply addr)", item[15:8], b);
            reply_phase = 2;
        end
        else
        begin
            item = exp_reply.pop_front();
            check_byte("tx_data (reply data)", item[7:0], b);
            reply_phase = 0;
        end
    endtask

    always @(posedge sys_clk)
    begin
        if (sys_rst_n && flash_rd_afull !== (flash_level >= tb_afull))
        begin
            $display("FAILED at %0t ns: flash_rd_afull expected %0b got %0b",
                     $time, flash_level >= tb_afull, flash_rd_afull);
            value_errors++;
        end
        if (sys_rst_n && tx_valid && tx_ready)
            take_tx_byte(tx_data);
        if (sys_rst_n && flash_rd_valid)
            flash_level++;
        lcg_state = lcg_next(lcg_state);
        tx_ready <= (lcg_state[17:16] != 2'b00);   // ready about 3 cycles in 4
    end

    // ----------------------------------------------------------------------
    // main sequence and watchdog
    // ----------------------------------------------------------------------
    initial
    begin
        rx_data        = 8'h00;
        rx_valid       = 1'b0;
        tx_ready       = 1'b0;
        status_word    = tb_status;
        flash_rd_data  = 8'h00;
        flash_rd_valid = 1'b0;
        value_errors   = 0;
        other_errors   = 0;
        assert_errors  = 0;
        reply_phase    = 0;
        flash_level    = 0;
        lcg_state      = 32'd50685;
        model_ctrl     = 5'b00001;   // switch 1, enables off
        add_entry(k_read,  8'h02, 8'h00, 8'h00);
        add_entry(k_write, 8'h02, 8'h3c, 8'h00);
        add_entry(k_read,  8'h02, 8'h00, 8'h3c);
        add_entry(k_write, 8'h0e, 8'h53, 8'h00);
        add_entry(k_read,  8'h0e, 8'h00, 8'h53);
        add_entry(k_write, 8'h04, 8'hff, 8'h00);
        add_entry(k_read,  8'h04, 8'h00, 8'h01);
        add_entry(k_read,  8'h00, 8'h00, tb_version);
        add_entry(k_read,  8'h31, 8'h00, tb_status[7:0]);
        add_entry(k_read,  8'h32, 8'h00, tb_status[15:8]);
        add_entry(k_read,  8'h05, 8'h00, 8'h00);   // unmapped
        add_entry(k_write, 8'h05, 8'hff, 8'h00);
        add_entry(k_junk,  8'h02, 8'he6, 8'h00);
        add_entry(k_read,  8'h02, 8'h00, 8'h3c);
        add_entry(k_write, 8'h0e, 8'h10, 8'h00);
        add_entry(k_read,  8'h0e, 8'h00, 8'h10);
        add_entry(k_read,  8'h02, 8'h00, 8'h3c);
        add_entry(k_read,  8'h04, 8'h00, 8'h01);
        add_entry(k_flash, 8'd12, 8'ha0, 8'h00);
        add_entry(k_read,  8'h31, 8'h00, tb_status[7:0]);
        add_entry(k_flash, 8'd8,  8'h10, 8'h00);
        add_entry(k_write, 8'h04, 8'h00, 8'h00);
        add_entry(k_read,  8'h04, 8'h00, 8'h00);
        add_entry(k_read,  8'h00, 8'h00, tb_version);
        add_entry(k_junk,  8'h0e, 8'h00, 8'h00);
        add_entry(k_read,  8'h0e, 8'h00, 8'h10);
        add_entry(k_flash, 8'd16, 8'hc0, 8'h00);
        add_entry(k_write, 8'h02, 8'ha5, 8'h00);
        add_entry(k_read,  8'h02, 8'h00, 8'ha5);
        add_entry(k_read,  8'h32, 8'h00, tb_status[15:8]);
        @(posedge sys_rst_n);
        @(posedge sys_clk);
        if (ctrl !== model_ctrl)
        begin
            $display("FAILED at %0t ns: ctrl expected %02h got %02h", $time, model_ctrl, ctrl);
            value_errors++;
        end
        foreach (stim[i])
            apply_entry(stim[i]);
        while (exp_flash.size() > 0 || exp_reply.size() > 0 || reply_phase != 0)
            @(posedge sys_clk);
        repeat (40) @(posedge sys_clk);   // catch stray bytes
        assert_errors = i_uart_reg_ctrl.u_uart_reg_ctrl_properties.assert_fails;
        $display("checks done: %0d value errors, %0d other errors, %0d assertion failures",
                 value_errors, other_errors, assert_errors);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin : watchdog
        #1;
        repeat (stim.size() * 40 + 400) @(posedge sys_clk);
        $display("timeout: tx stream did not drain, %0d flash bytes and %0d replies missing",
                 exp_flash.size(), exp_reply.size());
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- verilog.f
common/uart_reg_pkg.sv
source/sync_fifo.sv
cmd_path/frame_parser.sv
cmd_path/reg_bank.sv
source/tx_arbiter.sv
source/uart_reg_ctrl.sv
tests/tb_clock_gen.sv
tests/uart_reg_ctrl_properties.sv
tests/uart_reg_ctrl_tb.sv
